//--- common/ss_pkg.sv
package ss_pkg;

  // register bus address width
  localparam int ADDR_W = 16;

  // operand, modulus and result width of the field multiplier
  localparam int OP_W = 32;

  // one request on the parallel register bus
  // strobes are active low and idle high
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              rd_n;
    logic              wr_n;
    logic              ce_n;
  } ss_bus_t;

  // decoded fields of the frame command byte
  typedef struct packed {
    logic       is_write;
    logic [6:0] count;
  } ss_cmd_t;

  // command byte, loaded as a raw byte and read back as fields
  typedef union packed {
    logic [7:0] raw;
    ss_cmd_t    f;
  } ss_cmd_u;

  // register map, multi-byte registers are little endian
  localparam logic [ADDR_W-1:0] REG_A    = 16'h0000;
  localparam logic [ADDR_W-1:0] REG_B    = 16'h0004;
  localparam logic [ADDR_W-1:0] REG_P    = 16'h0008;
  localparam logic [ADDR_W-1:0] REG_CTRL = 16'h000C;
  localparam logic [ADDR_W-1:0] REG_RES  = 16'h0010;
  localparam logic [ADDR_W-1:0] REG_ID   = 16'h0014;

  // value returned by the id register
  localparam logic [7:0] ID_VALUE = 8'hEC;

  // control bit on write, status bits on read
  localparam int CTRL_START = 0;
  localparam int STAT_BUSY  = 0;
  localparam int STAT_DONE  = 1;

endpackage

//--- uart/uart_rx.sv
module uart_rx #(
  parameter int PBIT_RATE = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rxd,
  output logic       rx_valid,
  output logic [7:0] rx_data,
  output logic       frame_err
);

  typedef logic [$clog2(PBIT_RATE):0] cnt_t;
  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t     state;
  cnt_t       cnt;
  logic [2:0] bit_idx;
  // two sync stages plus one history stage for the edge detect
  logic [2:0] rxd_sync;
  logic       rx_bit;
  logic       rx_fall;

  assign rx_bit  = rxd_sync[1];
  assign rx_fall = rxd_sync[2] && !rxd_sync[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_sync  <= '1;
      state     <= st_idle;
      cnt       <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rxd_sync  <= {rxd_sync[1:0], rxd};
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
      case (state)
        st_idle: begin
          // half a bit puts the sample point at mid-bit
          if (rx_fall) begin
            state <= st_start;
            cnt   <= cnt_t'(PBIT_RATE / 2 - 1);
          end
        end
        st_start: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else if (rx_bit) begin
            // line went back high, treat it as a glitch
            state <= st_idle;
          end else begin
            state   <= st_data;
            cnt     <= cnt_t'(PBIT_RATE - 1);
            bit_idx <= '0;
          end
        end
        st_data: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else begin
            cnt     <= cnt_t'(PBIT_RATE - 1);
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        default: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else begin
            // stop bit sampled in its middle
            rx_valid  <= rx_bit;
            frame_err <= !rx_bit;
            state     <= st_idle;
          end
        end
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == st_data && cnt == '0) begin
      rx_data <= {rx_bit, rx_data[7:1]};
    end
  end

endmodule

//--- uart/uart_tx.sv
module uart_tx #(
  parameter int PBIT_RATE = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  logic [7:0] tx_data,
  output logic       tx_ready,
  output logic       txd
);

  typedef logic [$clog2(PBIT_RATE):0] cnt_t;

  // stop, data and start bits, bit 0 drives the line
  logic [9:0] shreg;
  cnt_t       cnt;
  logic [3:0] bit_idx;
  logic       busy;

  assign tx_ready = !busy;
  assign txd      = shreg[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shreg   <= '1;
      cnt     <= '0;
      bit_idx <= '0;
      busy    <= 1'b0;
    end else if (!busy) begin
      if (tx_valid) begin
        shreg   <= {1'b1, tx_data, 1'b0};
        cnt     <= cnt_t'(PBIT_RATE - 1);
        bit_idx <= '0;
        busy    <= 1'b1;
      end
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end else begin
      // next bit, ones fill in behind so the line idles high
      shreg   <= {1'b1, shreg[9:1]};
      cnt     <= cnt_t'(PBIT_RATE - 1);
      bit_idx <= bit_idx + 1'b1;
      // end of the stop bit
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

//--- hw/ss_bridge.sv
module ss_bridge (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx_valid,
  input  logic            frame_err,
  input  logic            tx_ready,
  input  logic [7:0]      rx_data,
  output logic            tx_valid,
  output logic [7:0]      tx_data,
  output ss_pkg::ss_bus_t bus,
  input  logic [7:0]      rdata,
  output logic            error
);

  import ss_pkg::*;

  typedef enum logic [2:0] {
    st_cmd, st_addr_lo, st_addr_hi, st_wdata, st_read, st_send
  } state_t;

  state_t     state;
  ss_cmd_u    cmd;
  logic [6:0] remain;
  // second cycle of a read strobe
  logic       rd_phase;
  logic       last;

  assign last = (remain == 7'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_cmd;
      cmd.raw  <= '0;
      remain   <= '0;
      rd_phase <= 1'b0;
      bus.addr <= '0;
      bus.rd_n <= 1'b1;
      bus.wr_n <= 1'b1;
      bus.ce_n <= 1'b1;
      tx_valid <= 1'b0;
      error    <= 1'b0;
    end else if (frame_err) begin
      // drop the frame, resync on the next command byte
      state    <= st_cmd;
      bus.rd_n <= 1'b1;
      bus.wr_n <= 1'b1;
      bus.ce_n <= 1'b1;
      tx_valid <= 1'b0;
      error    <= 1'b1;
    end else begin
      case (state)
        st_cmd: begin
          if (rx_valid) begin
            cmd.raw <= rx_data;
            state   <= st_addr_lo;
          end
        end
        st_addr_lo: begin
          if (rx_valid) begin
            bus.addr[7:0] <= rx_data;
            state         <= st_addr_hi;
          end
        end
        st_addr_hi: begin
          if (rx_valid) begin
            bus.addr[ADDR_W-1:8] <= rx_data;
            remain               <= cmd.f.count;
            rd_phase             <= 1'b0;
            // zero count closes the frame with no access
            if (cmd.f.count == 7'd0) begin
              state <= st_cmd;
            end else if (cmd.f.is_write) begin
              state <= st_wdata;
            end else begin
              state <= st_read;
            end
          end
        end
        st_wdata: begin
          if (!bus.wr_n) begin
            // strobe done, move to the next address
            bus.wr_n <= 1'b1;
            bus.ce_n <= 1'b1;
            bus.addr <= bus.addr + 1'b1;
            remain   <= remain - 1'b1;
            if (last) begin
              state <= st_cmd;
            end
          end else if (rx_valid) begin
            bus.wdata <= rx_data;
            bus.wr_n  <= 1'b0;
            bus.ce_n  <= 1'b0;
          end
        end
        st_read: begin
          if (bus.rd_n) begin
            bus.rd_n <= 1'b0;
            bus.ce_n <= 1'b0;
          end else if (!rd_phase) begin
            rd_phase <= 1'b1;
          end else begin
            // target registered rdata on the first edge
            bus.rd_n <= 1'b1;
            bus.ce_n <= 1'b1;
            rd_phase <= 1'b0;
            tx_data  <= rdata;
            tx_valid <= 1'b1;
            state    <= st_send;
          end
        end
        default: begin
          // hold the byte until the transmitter takes it
          if (tx_ready) begin
            tx_valid <= 1'b0;
            bus.addr <= bus.addr + 1'b1;
            remain   <= remain - 1'b1;
            state    <= last ? st_cmd : st_read;
          end
        end
      endcase
    end
  end

  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(!bus.rd_n && !bus.wr_n));

  a_wr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    !bus.wr_n |=> bus.wr_n);

endmodule

//--- fmul/fmul_regs.sv
module fmul_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ss_pkg::ss_bus_t         bus,
  output logic [7:0]              rdata,
  output logic                    start,
  output logic [ss_pkg::OP_W-1:0] a,
  output logic [ss_pkg::OP_W-1:0] b,
  output logic [ss_pkg::OP_W-1:0] p,
  input  logic                    busy,
  input  logic                    done,
  input  logic [ss_pkg::OP_W-1:0] result
);

  import ss_pkg::*;

  logic              wr_en;
  logic              rd_en;
  logic [1:0]        lane;
  logic [ADDR_W-3:0] word;
  logic              done_flag;
  logic [OP_W-1:0]   res_q;
  logic [7:0]        ctrl_rd;
  logic [7:0]        rd_mux;

  assign wr_en = !bus.ce_n && !bus.wr_n;
  assign rd_en = !bus.ce_n && !bus.rd_n;
  // byte lane and 32-bit word of the access
  assign lane  = bus.addr[1:0];
  assign word  = bus.addr[ADDR_W-1:2];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (word == REG_A[ADDR_W-1:2]) begin
        a[8*lane +: 8] <= bus.wdata;
      end
      if (word == REG_B[ADDR_W-1:2]) begin
        b[8*lane +: 8] <= bus.wdata;
      end
      if (word == REG_P[ADDR_W-1:2]) begin
        p[8*lane +: 8] <= bus.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start     <= 1'b0;
      done_flag <= 1'b0;
    end else begin
      start <= 1'b0;
      // a start while the core runs is dropped
      if (wr_en && bus.addr == REG_CTRL && bus.wdata[CTRL_START] && !busy && !start) begin
        start     <= 1'b1;
        done_flag <= 1'b0;
      end else if (done) begin
        done_flag <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      res_q <= result;
    end
  end

  always_comb begin
    ctrl_rd            = '0;
    ctrl_rd[STAT_BUSY] = busy;
    ctrl_rd[STAT_DONE] = done_flag;
    // unmapped addresses read as zero
    rd_mux = '0;
    if (word == REG_A[ADDR_W-1:2]) begin
      rd_mux = a[8*lane +: 8];
    end else if (word == REG_B[ADDR_W-1:2]) begin
      rd_mux = b[8*lane +: 8];
    end else if (word == REG_P[ADDR_W-1:2]) begin
      rd_mux = p[8*lane +: 8];
    end else if (word == REG_RES[ADDR_W-1:2]) begin
      rd_mux = res_q[8*lane +: 8];
    end else if (bus.addr == REG_CTRL) begin
      rd_mux = ctrl_rd;
    end else if (bus.addr == REG_ID) begin
      rd_mux = ID_VALUE;
    end
  end

  // read data is ready for the second strobe cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= rd_mux;
    end
  end

endmodule

//--- fmul/fmul_core.sv
module fmul_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [ss_pkg::OP_W-1:0] a,
  input  logic [ss_pkg::OP_W-1:0] b,
  input  logic [ss_pkg::OP_W-1:0] p,
  output logic                    busy,
  output logic                    done,
  output logic [ss_pkg::OP_W-1:0] result
);

  import ss_pkg::*;

  typedef logic [$clog2(OP_W)-1:0] cnt_t;

  cnt_t            cnt;
  logic            last;
  logic [OP_W-1:0] acc;
  logic [OP_W-1:0] a_r;
  logic [OP_W-1:0] p_r;
  // multiplier bits, msb first
  logic [OP_W-1:0] b_sh;
  // one extra bit so 2*acc and acc+a cannot overflow
  logic [OP_W:0]   dbl;
  logic [OP_W:0]   red1;
  logic [OP_W:0]   sum;
  logic [OP_W:0]   red2;

  assign last = (cnt == cnt_t'(OP_W - 1));

  always_comb begin
    dbl  = {acc, 1'b0};
    red1 = (dbl >= {1'b0, p_r}) ? dbl - {1'b0, p_r} : dbl;
    sum  = red1 + (b_sh[OP_W-1] ? {1'b0, a_r} : '0);
    red2 = (sum >= {1'b0, p_r}) ? sum - {1'b0, p_r} : sum;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // operands are captured so the host may rewrite them mid-run
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      acc  <= '0;
      a_r  <= a;
      p_r  <= p;
      b_sh <= b;
    end else if (busy) begin
      acc  <= red2[OP_W-1:0];
      b_sh <= b_sh << 1;
    end
    if (busy && last) begin
      result <= red2[OP_W-1:0];
    end
  end

  // fully reduced whenever the operand was in range
  a_res_reduced: assert property (@(posedge clk) disable iff (!rst_n)
    (done && a_r < p_r) |-> (result < p_r));

endmodule

//--- hw/ss_fmul_top.sv
module ss_fmul_top #(
  parameter int PBIT_RATE = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic rxd,
  output logic txd,
  output logic trigger,
  output logic error
);

  import ss_pkg::*;

  logic            rx_valid;
  logic            frame_err;
  logic [7:0]      rx_data;
  logic            tx_valid;
  logic            tx_ready;
  logic [7:0]      tx_data;
  ss_bus_t         bus;
  logic [7:0]      rdata;
  logic            start;
  logic            done;
  logic [OP_W-1:0] a;
  logic [OP_W-1:0] b;
  logic [OP_W-1:0] p;
  logic [OP_W-1:0] result;

  uart_rx #(
    .PBIT_RATE (PBIT_RATE)
  ) uart_rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rxd       (rxd),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .frame_err (frame_err)
  );

  uart_tx #(
    .PBIT_RATE (PBIT_RATE)
  ) uart_tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_ready (tx_ready),
    .txd      (txd)
  );

  ss_bridge ss_bridge_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (rx_valid),
    .frame_err (frame_err),
    .tx_ready  (tx_ready),
    .rx_data   (rx_data),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .bus       (bus),
    .rdata     (rdata),
    .error     (error)
  );

  // trigger marks the multiply window for capture
  fmul_regs fmul_regs_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .bus    (bus),
    .rdata  (rdata),
    .start  (start),
    .a      (a),
    .b      (b),
    .p      (p),
    .busy   (trigger),
    .done   (done),
    .result (result)
  );

  fmul_core fmul_core_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .a      (a),
    .b      (b),
    .p      (p),
    .busy   (trigger),
    .done   (done),
    .result (result)
  );

endmodule

//--- tests/ss_host_tasks.svh
`ifndef SS_HOST_TASKS_SVH
`define SS_HOST_TASKS_SVH

// host side of the serial link, included inside the testbench module
// data bytes of the next write frame
logic [7:0] wr_buf [$];
// bytes of the last read reply
logic [7:0] rd_buf [$];

// one uart character on rxd, lsb first, one stop bit
task automatic send_byte(input logic [7:0] data, input bit bad_stop);
  @(negedge clk);
  rxd = 1'b0;
  repeat (BIT_CLKS) @(negedge clk);
  for (int i = 0; i < 8; i++) begin
    rxd = data[i];
    repeat (BIT_CLKS) @(negedge clk);
  end
  // a low stop bit makes the receiver flag a framing fault
  rxd = !bad_stop;
  repeat (BIT_CLKS) @(negedge clk);
  rxd = 1'b1;
endtask

// one uart character from txd, sampled in the middle of each bit
task automatic recv_byte(output logic [7:0] data);
  int waited;
  waited = 0;
  data   = '0;
  while (txd !== 1'b0 && waited < RX_TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  if (txd !== 1'b0) begin
    timeout_abort("no start bit seen on txd");
  end else begin
    // half a bit to reach mid start bit
    repeat (BIT_CLKS / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      data[i] = txd;
    end
    repeat (BIT_CLKS) @(negedge clk);
    check_pin("txd stop bit", txd, 1'b1);
  end
endtask

// command, address low, address high, then the bytes in wr_buf
task automatic write_frame(input logic [ADDR_W-1:0] addr);
  ss_cmd_u cmd;
  cmd.f.is_write = 1'b1;
  cmd.f.count    = 7'(wr_buf.size());
  send_byte(cmd.raw, 1'b0);
  send_byte(addr[7:0], 1'b0);
  send_byte(addr[ADDR_W-1:8], 1'b0);
  foreach (wr_buf[i]) begin
    send_byte(wr_buf[i], 1'b0);
  end
endtask

// reply may start before the header is fully sent, so listen in parallel
task automatic read_frame(input logic [ADDR_W-1:0] addr, input int count);
  ss_cmd_u    cmd;
  logic [7:0] rx_b;
  cmd.f.is_write = 1'b0;
  cmd.f.count    = 7'(count);
  rd_buf.delete();
  fork
    begin
      send_byte(cmd.raw, 1'b0);
      send_byte(addr[7:0], 1'b0);
      send_byte(addr[ADDR_W-1:8], 1'b0);
    end
    begin
      repeat (count) begin
        recv_byte(rx_b);
        rd_buf.push_back(rx_b);
      end
    end
  join
endtask

`endif

//--- tests/tb_ss_fmul.sv
module tb_ss_fmul;

  import ss_pkg::*;

  localparam int BIT_CLKS    = 8;
  // covers a three byte header plus the bridge latency
  localparam int RX_TIMEOUT  = 48 * BIT_CLKS;
  localparam int POLL_LIMIT  = 8;
  localparam int NUM_VECTORS = 20;

  logic clk;
  logic rst_n;
  logic rxd;
  logic txd;
  logic trigger;
  logic error;

  // pending byte checks, drained on every rising edge
  logic [7:0] got_q [$];
  logic [7:0] exp_q [$];
  string      name_q [$];
  logic [7:0] cmp_got;
  logic [7:0] cmp_exp;
  string      cmp_name;

  int err_count;
  int check_count;
  int tests_run;
  int tests_failed;
  int test_err_base;

  logic [OP_W-1:0] va;
  logic [OP_W-1:0] vb;
  logic [OP_W-1:0] vp;
  logic [7:0]      status;

  ss_fmul_top #(
    .PBIT_RATE (BIT_CLKS)
  ) ss_fmul_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rxd     (rxd),
    .txd     (txd),
    .trigger (trigger),
    .error   (error)
  );

  always #5 clk = ~clk;

  // (a * b) mod p, computed wide so nothing overflows
  function automatic logic [OP_W-1:0] ref_fmul(input logic [OP_W-1:0] a,
                                               input logic [OP_W-1:0] b,
                                               input logic [OP_W-1:0] p);
    logic [63:0] prod;
    logic [63:0] rem;
    prod = 64'(a) * 64'(b);
    rem  = prod % 64'(p);
    return rem[OP_W-1:0];
  endfunction

  function automatic string reg_name(input logic [ADDR_W-1:0] addr);
    string base;
    if (addr < REG_B) begin
      base = "REG_A";
    end else if (addr < REG_P) begin
      base = "REG_B";
    end else if (addr < REG_CTRL) begin
      base = "REG_P";
    end else if (addr == REG_CTRL) begin
      base = "REG_CTRL";
    end else if (addr >= REG_RES && addr < REG_ID) begin
      base = "REG_RES";
    end else if (addr == REG_ID) begin
      base = "REG_ID";
    end else begin
      base = "unmapped";
    end
    return $sformatf("%s@0x%02h", base, addr);
  endfunction

  task automatic timeout_abort(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_pin(input string name, input logic got, input logic exp);
    check_count++;
    assert (got === exp) else begin
      $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  `include "ss_host_tasks.svh"

  // compare process for every read byte
  always @(posedge clk) begin
    while (got_q.size() > 0) begin
      cmp_got  = got_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_name = name_q.pop_front();
      check_count++;
      assert (cmp_got === cmp_exp) else begin
        $display("Fail t=%0t %s got 0x%02h expected 0x%02h",
                 $time, cmp_name, cmp_got, cmp_exp);
        err_count++;
      end
    end
  end

  task automatic check_byte(input logic [ADDR_W-1:0] addr, input logic [7:0] got,
                            input logic [7:0] exp);
    got_q.push_back(got);
    exp_q.push_back(exp);
    name_q.push_back(reg_name(addr));
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic drain_checks();
    int waited;
    waited = 0;
    while (got_q.size() > 0 && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (got_q.size() > 0) begin
      timeout_abort("byte compare queue did not drain");
    end
  endtask

  task automatic end_test(input string name);
    drain_checks();
    tests_run++;
    if (err_count == test_err_base) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  // a, b and p in one frame, little endian, from REG_A upward
  task automatic load_operands(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b,
                               input logic [OP_W-1:0] p);
    wr_buf.delete();
    for (int i = 0; i < 4; i++) begin
      wr_buf.push_back(a[8*i +: 8]);
    end
    for (int i = 0; i < 4; i++) begin
      wr_buf.push_back(b[8*i +: 8]);
    end
    for (int i = 0; i < 4; i++) begin
      wr_buf.push_back(p[8*i +: 8]);
    end
    write_frame(REG_A);
  endtask

  task automatic start_mult();
    wr_buf.delete();
    wr_buf.push_back(8'(1 << CTRL_START));
    write_frame(REG_CTRL);
  endtask

  task automatic poll_done(output logic [7:0] ctrl);
    int polls;
    polls = 0;
    ctrl  = '0;
    while (!ctrl[STAT_DONE] && polls < POLL_LIMIT) begin
      read_frame(REG_CTRL, 1);
      ctrl = rd_buf[0];
      polls++;
    end
    if (!ctrl[STAT_DONE]) begin
      timeout_abort("STAT_DONE never read back as set");
    end
  endtask

  task automatic check_result(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b,
                              input logic [OP_W-1:0] p);
    logic [OP_W-1:0] exp;
    exp = ref_fmul(a, b, p);
    read_frame(REG_RES, 4);
    for (int i = 0; i < 4; i++) begin
      check_byte(REG_RES + ADDR_W'(i), rd_buf[i], exp[8*i +: 8]);
    end
  endtask

  // busy starts a few cycles after the control write lands
  task automatic wait_trigger();
    int waited;
    waited = 0;
    while (trigger !== 1'b1 && waited < 4 * BIT_CLKS) begin
      @(negedge clk);
      waited++;
    end
    check_pin("trigger after start", trigger, 1'b1);
  endtask

  task automatic wait_error();
    int waited;
    waited = 0;
    while (error !== 1'b1 && waited < 4 * BIT_CLKS) begin
      @(negedge clk);
      waited++;
    end
    check_pin("error after low stop bit", error, 1'b1);
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    rxd           = 1'b1;
    err_count     = 0;
    check_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    void'($urandom(32'h2c1e68b2));
    apply_reset();

    // one 12 byte write and one 12 byte read walk the whole operand space
    va = $urandom;
    vb = $urandom;
    vp = $urandom;
    load_operands(va, vb, vp);
    read_frame(REG_A, 12);
    for (int i = 0; i < 12; i++) begin
      check_byte(REG_A + ADDR_W'(i), rd_buf[i], wr_buf[i]);
    end
    end_test("operand readback with address increment");

    read_frame(REG_ID, 1);
    check_byte(REG_ID, rd_buf[0], 8'hEC);
    read_frame(16'h0020, 1);
    check_byte(16'h0020, rd_buf[0], 8'h00);
    end_test("id and unmapped reads");

    for (int n = 0; n < NUM_VECTORS; n++) begin
      vp = $urandom;
      if (vp == '0) begin
        vp = 32'd1;
      end
      va = $urandom % vp;
      vb = $urandom;
      load_operands(va, vb, vp);
      start_mult();
      poll_done(status);
      check_result(va, vb, vp);
    end
    end_test("random modular multiplies");

    // modulus near the top of the range exercises both reductions
    vp = 32'hFFFF_FFFB;
    va = 32'h1234_5678;
    vb = 32'h9ABC_DEF0;
    load_operands(va, vb, vp);
    start_mult();
    wait_trigger();
    poll_done(status);
    check_pin("trigger after done", trigger, 1'b0);
    check_byte(REG_CTRL, status, 8'(1 << STAT_DONE));
    check_result(va, vb, vp);
    end_test("trigger window and status bits");

    send_byte(8'h5A, 1'b1);
    wait_error();
    read_frame(REG_ID, 1);
    check_byte(REG_ID, rd_buf[0], 8'hEC);
    check_pin("error held after good frame", error, 1'b1);
    apply_reset();
    check_pin("error after reset", error, 1'b0);
    end_test("framing error flag");

    $display("tests %0d, with errors %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+tests
common/ss_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hw/ss_bridge.sv
fmul/fmul_regs.sv
fmul/fmul_core.sv
hw/ss_fmul_top.sv
tests/tb_ss_fmul.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_ss_fmul
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "test: FAIL"; exit 1; \
	else \
	  echo "test: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
